// File: sim.f
+incdir+include
design/cdc_bridge_pkg.sv
design/dual_port_ram.sv
design/gray_ptr_sync.sv
design/async_fifo.sv
design/flush_timer.sv
design/rd_drain_ctrl.sv
design/cdc_burst_bridge.sv
testbench/cdc_burst_bridge_assert.sv
testbench/cdc_burst_bridge_tb.sv

// File: Makefile
VERILATOR := verilator
FLAGS     := --binary --timing --assert -j 0
TOP       := cdc_burst_bridge_tb
FILELIST  := sim.f
OBJ_DIR   := obj_dir

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q '^>>> PASS$$'

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

// File: testbench/cdc_burst_bridge_tb.sv
`timescale 1ns/1ps
`include "cdc_bridge_macros.svh"

module cdc_burst_bridge_tb;

  localparam int WR_HALF    = 4;
  localparam int RD_HALF    = 6;
  localparam int RD_PERIOD  = 2 * RD_HALF;
  localparam int NUM_SCEN   = 6;
  localparam int TIME_NONE  = 0;
  localparam int TIME_WMARK = 1;  // Watermark must start the burst
  localparam int TIME_FLUSH = 2;  // Only the flush timer may start the burst

  typedef struct packed {
    int words;
    bit b2b;
    int duty;      // out_ready high on this many of 8 cycles
    bit hold;      // out_ready low until all writes are issued
    int accepted;
    int timing;
  } scen_t;

  // A stalled output register holds one word on top of a full FIFO
  scen_t scen [NUM_SCEN] = '{
    '{20, 1'b1, 8, 1'b1, `CDC_FIFO_DEPTH + 1, TIME_NONE},
    '{`CDC_AEMPTY + 1, 1'b1, 8, 1'b0, `CDC_AEMPTY + 1, TIME_WMARK},
    '{3, 1'b1, 8, 1'b0, 3, TIME_FLUSH},
    '{16, 1'b0, 3, 1'b0, 16, TIME_NONE},
    '{12, 1'b1, 5, 1'b0, 12, TIME_NONE},
    '{9, 1'b0, 8, 1'b0, 9, TIME_NONE}
  };

  logic                  wr_clk = 1'b0;
  logic                  rd_clk = 1'b0;
  logic                  wr_rst_n;
  logic                  rd_rst_n;
  logic                  wr_en;
  cdc_bridge_pkg::word_t wr_data;
  logic                  full;
  logic                  afull;
  logic                  out_valid;
  cdc_bridge_pkg::word_t out_data;
  logic                  out_ready;

  logic [31:0]           lfsr = 32'hf69f;
  cdc_bridge_pkg::word_t expected_q [$];
  int                    errors = 0;
  int                    words_checked = 0;
  int                    accepted;
  int                    out_count;
  logic                  writes_done;
  realtime               first_wr_t;
  realtime               last_wr_t;
  realtime               first_out_t;
  realtime               last_out_t;

  always #WR_HALF wr_clk = ~wr_clk;
  always #RD_HALF rd_clk = ~rd_clk;

  cdc_burst_bridge i_cdc_burst_bridge (
    .wr_clk    (wr_clk),
    .wr_rst_n  (wr_rst_n),
    .wr_en     (wr_en),
    .wr_data   (wr_data),
    .full      (full),
    .afull     (afull),
    .rd_clk    (rd_clk),
    .rd_rst_n  (rd_rst_n),
    .out_valid (out_valid),
    .out_data  (out_data),
    .out_ready (out_ready)
  );

  // Taps 32, 22, 2 and 1
  function automatic logic [31:0] next_bits(input int n);
    logic [31:0] bits;
    logic        fb;
    bits = '0;
    for (int i = 0; i < n; i++) begin
      fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
      lfsr = {lfsr[30:0], fb};
      bits = {bits[30:0], fb};
    end
    return bits;
  endfunction

  task automatic check_value(input string name, input logic [31:0] actual,
                             input logic [31:0] expected);
    if (actual !== expected) begin
      $display("[ERROR] %0t %s: got %0h, expected %0h", $time, name, actual, expected);
      errors++;
    end
  endtask

  task automatic report_failure(input string msg);
    $display("[ERROR] %0t %s", $time, msg);
    errors++;
  endtask

  // Level is the accepted count, less the one word the output register may hold
  task automatic check_fill_flags();
    if (accepted < `CDC_AFULL) check_value("afull", 32'(afull), 32'd0);
    if (accepted > `CDC_AFULL) check_value("afull", 32'(afull), 32'd1);
    if (accepted < `CDC_FIFO_DEPTH) check_value("full", 32'(full), 32'd0);
    if (accepted > `CDC_FIFO_DEPTH) check_value("full", 32'(full), 32'd1);
  endtask

  task automatic write_words(input scen_t s);
    logic took;
    @(negedge wr_clk);
    for (int i = 0; i < s.words; i++) begin
      if (!s.b2b) begin
        wr_en = 1'b0;
        repeat (next_bits(2)) @(negedge wr_clk);
      end
      wr_en   = 1'b1;
      wr_data = cdc_bridge_pkg::word_t'(next_bits(`CDC_DATA_WIDTH));
      @(posedge wr_clk);
      took = !full;  // The full value the FIFO sees on this edge
      if (took) begin
        expected_q.push_back(wr_data);
        accepted++;
        if (accepted == 1) first_wr_t = $realtime;
        last_wr_t = $realtime;
      end
      @(negedge wr_clk);
      if (took && s.hold) check_fill_flags();
    end
    wr_en       = 1'b0;
    writes_done = 1'b1;
  endtask

  task automatic drive_ready(input scen_t s);
    do begin
      @(negedge rd_clk);
      if (s.hold && !writes_done) out_ready = 1'b0;
      else out_ready = (next_bits(3) < s.duty);
    end while (!writes_done || expected_q.size() != 0);
  endtask

  // ********************
  // Scoreboard
  // ********************

  task automatic watch_output();
    logic                  held;
    cdc_bridge_pkg::word_t held_data;
    held      = 1'b0;
    held_data = '0;
    forever begin
      @(posedge rd_clk);
      if (held) begin
        check_value("out_valid", 32'(out_valid), 32'd1);
        check_value("out_data", 32'(out_data), 32'(held_data));
      end
      if (out_valid && out_ready) begin
        if (expected_q.size() == 0) begin
          report_failure("a word left the bridge with no accepted word left to match");
        end else begin
          check_value("out_data", 32'(out_data), 32'(expected_q.pop_front()));
          words_checked++;
        end
        if (out_count == 0) first_out_t = $realtime;
        last_out_t = $realtime;
        out_count++;
      end
      held      = out_valid && !out_ready;
      held_data = out_data;
    end
  endtask

  task automatic run_scenario(input int idx);
    scen_t s;
    int    err_base;
    real   flush_ns;
    s           = scen[idx];
    err_base    = errors;
    flush_ns    = real'(`CDC_FLUSH_CYCLES * RD_PERIOD);
    accepted    = 0;
    out_count   = 0;
    writes_done = 1'b0;
    fork
      write_words(s);
      drive_ready(s);
    join
    out_ready = 1'b1;
    repeat (10) @(negedge rd_clk);  // A dropped word would surface here
    check_value("accepted words", accepted, s.accepted);
    check_value("words out", out_count, s.accepted);
    if (s.timing == TIME_WMARK && first_out_t - last_wr_t >= flush_ns) begin
      report_failure("the watermark did not start a burst before the flush time");
    end
    if (s.timing == TIME_FLUSH && first_out_t - first_wr_t <= flush_ns) begin
      report_failure("words left before the flush timer could have expired");
    end
    if (s.timing == TIME_FLUSH && last_out_t - first_wr_t > flush_ns + 20.0 * RD_PERIOD) begin
      report_failure("the flushed words did not all leave in time");
    end
    $display("scenario %0d: %0d written, %0d accepted, %0d out, %0d errors",
             idx, s.words, accepted, out_count, errors - err_base);
  endtask

  initial begin
    $timeformat(-9, 0, " ns", 0);
    wr_rst_n  = 1'b0;
    rd_rst_n  = 1'b0;
    wr_en     = 1'b0;
    wr_data   = '0;
    out_ready = 1'b0;
    fork
      begin
        repeat (3) @(posedge wr_clk);
        @(negedge wr_clk);
        wr_rst_n = 1'b1;
      end
      begin
        repeat (3) @(posedge rd_clk);
        @(negedge rd_clk);
        rd_rst_n = 1'b1;
      end
    join
    check_value("full", 32'(full), 32'd0);
    check_value("afull", 32'(afull), 32'd0);
    check_value("out_valid", 32'(out_valid), 32'd0);
    fork
      watch_output();
    join_none
    for (int i = 0; i < NUM_SCEN; i++) begin
      run_scenario(i);
    end
    $display("scenarios: %0d, words checked: %0d, errors: %0d",
             NUM_SCEN, words_checked, errors);
    if (errors == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

  // Limit grows with the total number of words in the table
  initial begin
    int total;
    total = 0;
    for (int i = 0; i < NUM_SCEN; i++) begin
      total += scen[i].words;
    end
    #(total * 40 * RD_PERIOD + 2000);
    $display("[ERROR] %0t the run did not finish before the watchdog limit", $time);
    $display(">>> FAIL");
    $finish;
  end

endmodule

// File: testbench/cdc_burst_bridge_assert.sv
`timescale 1ns/1ps

module cdc_burst_bridge_assert (
  input logic                         rd_clk,
  input logic                         rd_rst_n,
  input logic                         empty,
  input logic                         rd_en,
  input logic                         out_valid,
  input logic                         out_ready,
  input cdc_bridge_pkg::word_t        out_data,
  input cdc_bridge_pkg::drain_state_t state
);

  // A pop is only requested when the FIFO has a word to give
  no_pop_when_empty: assert property (
    @(posedge rd_clk) disable iff (!rd_rst_n) !(rd_en && empty)
  ) else $error("rd_en high while empty is high");

  output_holds_in_stall: assert property (
    @(posedge rd_clk) disable iff (!rd_rst_n)
    out_valid && !out_ready |=> out_valid && $stable(out_data)
  ) else $error("out_valid or out_data changed during a stall");

  state_is_legal: assert property (
    @(posedge rd_clk) disable iff (!rd_rst_n)
    state inside {cdc_bridge_pkg::IDLE, cdc_bridge_pkg::DRAIN}
  ) else $error("drain FSM left its legal states");

endmodule

bind rd_drain_ctrl cdc_burst_bridge_assert i_cdc_burst_bridge_assert (
  .rd_clk    (rd_clk),
  .rd_rst_n  (rd_rst_n),
  .empty     (empty),
  .rd_en     (rd_en),
  .out_valid (out_valid),
  .out_ready (out_ready),
  .out_data  (out_data),
  .state     (state)
);

// File: design/cdc_burst_bridge.sv
`timescale 1ns/1ps

module cdc_burst_bridge (
  input  logic                  wr_clk,
  input  logic                  wr_rst_n,
  input  logic                  wr_en,
  input  cdc_bridge_pkg::word_t wr_data,
  output logic                  full,
  output logic                  afull,
  input  logic                  rd_clk,
  input  logic                  rd_rst_n,
  output logic                  out_valid,
  output cdc_bridge_pkg::word_t out_data,
  input  logic                  out_ready
);

  logic                  empty;
  logic                  aempty;
  logic                  rd_en;
  cdc_bridge_pkg::word_t rd_data;
  logic                  run;
  logic                  expired;

  // Crosses words from the producer clock into the read clock
  async_fifo i_async_fifo (
    .wr_clk   (wr_clk),
    .wr_rst_n (wr_rst_n),
    .wr_en    (wr_en),
    .wr_data  (wr_data),
    .full     (full),
    .afull    (afull),
    .rd_clk   (rd_clk),
    .rd_rst_n (rd_rst_n),
    .rd_en    (rd_en),
    .rd_data  (rd_data),
    .empty    (empty),
    .aempty   (aempty)
  );

  flush_timer i_flush_timer (
    .rd_clk   (rd_clk),
    .rd_rst_n (rd_rst_n),
    .run      (run),
    .expired  (expired)
  );

  rd_drain_ctrl i_rd_drain_ctrl (
    .rd_clk    (rd_clk),
    .rd_rst_n  (rd_rst_n),
    .empty     (empty),
    .aempty    (aempty),
    .expired   (expired),
    .run       (run),
    .rd_en     (rd_en),
    .rd_data   (rd_data),
    .out_ready (out_ready),
    .out_valid (out_valid),
    .out_data  (out_data)
  );

endmodule

// File: design/rd_drain_ctrl.sv
`timescale 1ns/1ps

module rd_drain_ctrl (
  input  logic                  rd_clk,
  input  logic                  rd_rst_n,
  input  logic                  empty,
  input  logic                  aempty,
  input  logic                  expired,
  output logic                  run,
  output logic                  rd_en,
  input  cdc_bridge_pkg::word_t rd_data,
  input  logic                  out_ready,
  output logic                  out_valid,
  output cdc_bridge_pkg::word_t out_data
);

  cdc_bridge_pkg::drain_state_t state;
  cdc_bridge_pkg::drain_state_t state_nxt;
  logic                         pending;  // Popped word on its way from the RAM

  // ********************
  // Drain FSM
  // ********************

  always_comb begin
    state_nxt = state;
    run       = 1'b0;
    rd_en     = 1'b0;
    case (state)
      cdc_bridge_pkg::IDLE: begin
        run = !empty;  // Age the waiting words
        if (!aempty || expired) begin
          state_nxt = cdc_bridge_pkg::DRAIN;
        end
      end
      cdc_bridge_pkg::DRAIN: begin
        // One word in flight at a time
        rd_en = !empty && !pending && (!out_valid || out_ready);
        if (empty && !pending && !out_valid) begin
          state_nxt = cdc_bridge_pkg::IDLE;
        end
      end
      default: begin
        state_nxt = cdc_bridge_pkg::IDLE;
      end
    endcase
  end

  always_ff @(posedge rd_clk or negedge rd_rst_n) begin
    if (!rd_rst_n) begin
      state     <= cdc_bridge_pkg::IDLE;
      pending   <= 1'b0;
      out_valid <= 1'b0;
    end else begin
      state   <= state_nxt;
      pending <= rd_en;  // The RAM registers the word on this same edge
      if (pending) begin
        out_valid <= 1'b1;
      end else if (out_ready) begin
        out_valid <= 1'b0;
      end
    end
  end

  // ********************
  // Output register
  // ********************

  always_ff @(posedge rd_clk) begin
    if (pending) begin
      out_data <= rd_data;
    end
  end

endmodule

// File: design/flush_timer.sv
`timescale 1ns/1ps
`include "cdc_bridge_macros.svh"

module flush_timer (
  input  logic rd_clk,
  input  logic rd_rst_n,
  input  logic run,
  output logic expired
);

  typedef logic [$clog2(`CDC_FLUSH_CYCLES+1)-1:0] cnt_t;

  cnt_t count;

  // Counts consecutive cycles with run high and parks at the limit
  always_ff @(posedge rd_clk or negedge rd_rst_n) begin
    if (!rd_rst_n) begin
      count <= '0;
    end else if (!run) begin
      count <= '0;
    end else if (!expired) begin
      count <= count + cnt_t'(1);
    end
  end

  // Stays high while parked, falls once run drops and the count clears
  assign expired = (count == cnt_t'(`CDC_FLUSH_CYCLES));

endmodule

// File: design/async_fifo.sv
`timescale 1ns/1ps
`include "cdc_bridge_macros.svh"

module async_fifo (
  input  logic                  wr_clk,
  input  logic                  wr_rst_n,
  input  logic                  wr_en,
  input  cdc_bridge_pkg::word_t wr_data,
  output logic                  full,
  output logic                  afull,
  input  logic                  rd_clk,
  input  logic                  rd_rst_n,
  input  logic                  rd_en,
  output cdc_bridge_pkg::word_t rd_data,
  output logic                  empty,
  output logic                  aempty
);

  logic                 wr_vld;
  cdc_bridge_pkg::ptr_t wr_bin;
  cdc_bridge_pkg::ptr_t wr_bin_nxt;
  cdc_bridge_pkg::ptr_t wr_gray;
  cdc_bridge_pkg::ptr_t rd_bin_wsync;  // Read pointer seen from the write side
  cdc_bridge_pkg::ptr_t wr_level_nxt;

  logic                 rd_vld;
  cdc_bridge_pkg::ptr_t rd_bin;
  cdc_bridge_pkg::ptr_t rd_bin_nxt;
  cdc_bridge_pkg::ptr_t rd_gray;
  cdc_bridge_pkg::ptr_t wr_bin_rsync;  // Write pointer seen from the read side
  cdc_bridge_pkg::ptr_t rd_level_nxt;

  // Requests against a blocking flag are simply ignored
  assign wr_vld = wr_en && !full;
  assign rd_vld = rd_en && !empty;

  dual_port_ram i_dual_port_ram (
    .wr_clk  (wr_clk),
    .wr_en   (wr_vld),
    .wr_addr (wr_bin[`CDC_ADDR_WIDTH-1:0]),
    .wr_data (wr_data),
    .rd_clk  (rd_clk),
    .rd_en   (rd_vld),
    .rd_addr (rd_bin[`CDC_ADDR_WIDTH-1:0]),
    .rd_data (rd_data)
  );

  // ********************
  // Write domain
  // ********************

  assign wr_bin_nxt   = wr_bin + cdc_bridge_pkg::ptr_t'(wr_vld);
  assign wr_level_nxt = wr_bin_nxt - rd_bin_wsync;

  gray_ptr_sync i_rd_ptr_sync (
    .clk     (wr_clk),
    .rst_n   (wr_rst_n),
    .gray_in (rd_gray),
    .bin_out (rd_bin_wsync)
  );

  always_ff @(posedge wr_clk or negedge wr_rst_n) begin
    if (!wr_rst_n) begin
      wr_bin  <= '0;
      wr_gray <= '0;
      full    <= 1'b0;
      afull   <= 1'b0;
    end else begin
      wr_bin  <= wr_bin_nxt;
      wr_gray <= wr_bin_nxt ^ (wr_bin_nxt >> 1);
      // Flags look at the next pointer so an accepted write counts at once
      full    <= (wr_level_nxt == cdc_bridge_pkg::ptr_t'(`CDC_FIFO_DEPTH));
      afull   <= (wr_level_nxt >= cdc_bridge_pkg::ptr_t'(`CDC_AFULL));
    end
  end

  // ********************
  // Read domain
  // ********************

  assign rd_bin_nxt   = rd_bin + cdc_bridge_pkg::ptr_t'(rd_vld);
  assign rd_level_nxt = wr_bin_rsync - rd_bin_nxt;

  gray_ptr_sync i_wr_ptr_sync (
    .clk     (rd_clk),
    .rst_n   (rd_rst_n),
    .gray_in (wr_gray),
    .bin_out (wr_bin_rsync)
  );

  always_ff @(posedge rd_clk or negedge rd_rst_n) begin
    if (!rd_rst_n) begin
      rd_bin  <= '0;
      rd_gray <= '0;
      empty   <= 1'b1;
      aempty  <= 1'b1;
    end else begin
      rd_bin  <= rd_bin_nxt;
      rd_gray <= rd_bin_nxt ^ (rd_bin_nxt >> 1);
      empty   <= (wr_bin_rsync == rd_bin_nxt);
      aempty  <= (rd_level_nxt <= cdc_bridge_pkg::ptr_t'(`CDC_AEMPTY));
    end
  end

  // The synchronized pointers lag, so full and empty stay conservative

endmodule

// File: design/gray_ptr_sync.sv
`timescale 1ns/1ps

module gray_ptr_sync (
  input  logic                 clk,
  input  logic                 rst_n,
  input  cdc_bridge_pkg::ptr_t gray_in,
  output cdc_bridge_pkg::ptr_t bin_out
);

  cdc_bridge_pkg::ptr_t sync_q1;
  cdc_bridge_pkg::ptr_t sync_q2;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      sync_q1 <= '0;
      sync_q2 <= '0;
    end else begin
      sync_q1 <= gray_in;  // First stage may go metastable
      sync_q2 <= sync_q1;
    end
  end

  // Each binary bit is the XOR of the Gray bits at and above it
  always_comb begin
    for (int i = 0; i < $bits(bin_out); i++) begin
      bin_out[i] = ^(sync_q2 >> i);
    end
  end

endmodule

// File: design/dual_port_ram.sv
`timescale 1ns/1ps
`include "cdc_bridge_macros.svh"

module dual_port_ram (
  input  logic                      wr_clk,
  input  logic                      wr_en,
  input  logic [`CDC_ADDR_WIDTH-1:0] wr_addr,
  input  cdc_bridge_pkg::word_t     wr_data,
  input  logic                      rd_clk,
  input  logic                      rd_en,
  input  logic [`CDC_ADDR_WIDTH-1:0] rd_addr,
  output cdc_bridge_pkg::word_t     rd_data
);

  cdc_bridge_pkg::word_t mem [`CDC_FIFO_DEPTH];

  // Write port, owned by the producer clock
  always_ff @(posedge wr_clk) begin
    if (wr_en) begin
      mem[wr_addr] <= wr_data;
    end
  end

  // Registered read port, output holds between pops
  always_ff @(posedge rd_clk) begin
    if (rd_en) begin
      rd_data <= mem[rd_addr];
    end
  end

endmodule

// File: design/cdc_bridge_pkg.sv
`include "cdc_bridge_macros.svh"

package cdc_bridge_pkg;

  // One payload word as it travels through the bridge
  typedef logic [`CDC_DATA_WIDTH-1:0] word_t;

  // FIFO pointer with a wrap bit above the RAM address
  typedef logic [`CDC_ADDR_WIDTH:0] ptr_t;

  // Read side drain FSM
  typedef enum logic {
    IDLE,   // Holding words back
    DRAIN   // Releasing a burst
  } drain_state_t;

endpackage

// File: include/cdc_bridge_macros.svh
`ifndef CDC_BRIDGE_MACROS_SVH
`define CDC_BRIDGE_MACROS_SVH

// Payload and storage geometry
`define CDC_DATA_WIDTH 8
`define CDC_FIFO_DEPTH 16
`define CDC_ADDR_WIDTH 4  // Must stay equal to log2 of the depth

// Flag thresholds, in words
`define CDC_AFULL  14
`define CDC_AEMPTY 4      // Also serves as the drain watermark

// Read clock cycles that waiting words may sit before a forced flush
`define CDC_FLUSH_CYCLES 32

`endif
